//--- filelist.f
+incdir+include
hdl/memsys_pkg.sv
hdl/instrCache.sv
hdl/dataCache.sv
hdl/busArbiter.sv
hdl/blockMemory.sv
hdl/memSystem.sv
bench/clockGen.sv
bench/memSystem_chk.sv
bench/memSystemTb.sv

//--- Bender.yml
package:
  name: memsys

sources:
  # design
  - include_dirs:
      - include
    files:
      - hdl/memsys_pkg.sv
      - hdl/instrCache.sv
      - hdl/dataCache.sv
      - hdl/busArbiter.sv
      - hdl/blockMemory.sv
      - hdl/memSystem.sv

  # testbench
  - target: test
    include_dirs:
      - include
    files:
      - bench/clockGen.sv
      - bench/memSystem_chk.sv
      - bench/memSystemTb.sv

//--- bench/memSystemTb.sv
`include "memsys_config.svh"

module memSystemTb;

  timeunit 1ns;
  timeprecision 1ps;

  import memsys_pkg::*;

  // accesses per test
  localparam int FetchCount   = 72;
  localparam int ReadCount    = 64;
  localparam int WriteCount   = 4 * (`BLOCK_WORDS + 1);
  localparam int EvictCount   = 8 + 4 * `BLOCK_WORDS;
  localparam int MixCount     = 200;
  localparam int ResetCycles  = 10;
  localparam int NumAccesses  = FetchCount + ReadCount + WriteCount + EvictCount + 2 * MixCount;
  localparam int TimeoutLimit = NumAccesses * (2 * `MEM_LATENCY + 4) * 2 + ResetCycles;
  localparam int WordIdxW     = $clog2(`MEM_WORDS);

  // separate regions, no coherence between the caches
  localparam addr_t InstrBase = 32'h0000_0000;
  localparam addr_t DataBase  = 32'h0000_0800;
  // four blocks that all land in data set 3
  localparam addr_t EvictBase = 32'h0000_0a30;

  logic  clk;
  logic  arstN;
  addr_t pcF;
  addr_t dataAdrM;
  word_t writeDataM;
  logic  memWriteM;
  logic  memReadM;
  word_t instrF;
  logic  iStall;
  word_t readDataM;
  logic  dStall;

  logic   fetchOn;
  int     testNo;
  integer seed;
  int     cycles;
  int     errorCount = 0;
  int     checkCount = 0;
  word_t  shadow [`MEM_WORDS];
  addr_t  mixAddr [MixCount];
  logic   mixWrite [MixCount];
  word_t  mixData [MixCount];
  addr_t  mixFetch [MixCount];

  clockGen i_clockGen (
    .clk   (clk),
    .arstN (arstN)
  );

  memSystem i_memSystem (
    .clk        (clk),
    .arstN      (arstN),
    .pcF        (pcF),
    .dataAdrM   (dataAdrM),
    .writeDataM (writeDataM),
    .memWriteM  (memWriteM),
    .memReadM   (memReadM),
    .instrF     (instrF),
    .iStall     (iStall),
    .readDataM  (readDataM),
    .dStall     (dStall)
  );

  // power-on content, n * 9e3779b1 + n folded into one product
  function automatic word_t initWord(int n);
    return word_t'(n) * 32'h9e37_79b2;
  endfunction

  // expected word from the shadow copy of memory
  function automatic word_t expectedWord(addr_t a);
    return shadow[a[2 +: WordIdxW]];
  endfunction

  function automatic string testLabel(int t);
    case (t)
      1:       return "fetch";
      2:       return "dataRead";
      3:       return "writeRead";
      4:       return "dirtyEvict";
      5:       return "mixed";
      default: return "reset";
    endcase
  endfunction

  task automatic checkValue(string name, word_t expected, word_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // hold the fetch address until iStall is seen low on an edge
  task automatic fetchWord(addr_t a);
    pcF     <= a;
    fetchOn <= 1'b1;
    do begin
      @(posedge clk);
    end while (iStall);
  endtask

  task automatic dataAccess(addr_t a, logic write, word_t wdata);
    dataAdrM   <= a;
    writeDataM <= wdata;
    memWriteM  <= write;
    memReadM   <= !write;
    do begin
      @(posedge clk);
    end while (dStall);
  endtask

  task automatic dataIdle();
    memWriteM <= 1'b0;
    memReadM  <= 1'b0;
    @(posedge clk);
  endtask

  task automatic finishRun();
    int assertErrs;
    assertErrs = i_memSystem.i_memSystemChk.assertFails;
    $display("checks %0d, mismatches %0d, assertion failures %0d",
             checkCount, errorCount, assertErrs);
    if (errorCount == 0 && assertErrs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // data port compare, a write updates the shadow as it commits
  always @(posedge clk) begin
    if (arstN && (memReadM || memWriteM) && !dStall) begin
      if (memWriteM) begin
        shadow[dataAdrM[2 +: WordIdxW]] = writeDataM;
      end else begin
        checkValue($sformatf("%s data %h", testLabel(testNo), dataAdrM),
                   expectedWord(dataAdrM), readDataM);
      end
    end
  end

  // fetch port compare
  always @(posedge clk) begin
    if (arstN && fetchOn && !iStall) begin
      checkValue($sformatf("%s instr %h", testLabel(testNo), pcF),
                 expectedWord(pcF), instrF);
    end
  end

  // hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutLimit) begin
      $display("Timeout after %0d cycles, a stall never fell and the run hung", cycles);
      errorCount++;
      finishRun();
    end
  end

  task automatic sweepFetches();
    testNo <= 1;
    // cold misses, then the same lines again as hits
    for (int i = 0; i < 32; i++) begin
      fetchWord(InstrBase + addr_t'(4 * i));
    end
    for (int i = 0; i < 32; i++) begin
      fetchWord(InstrBase + addr_t'(4 * i));
    end
    // 0x100 shares line 0, evict and come back
    for (int i = 0; i < 4; i++) begin
      fetchWord(InstrBase + 32'h100 + addr_t'(4 * i));
    end
    for (int i = 0; i < 4; i++) begin
      fetchWord(InstrBase + addr_t'(4 * i));
    end
    fetchOn <= 1'b0;
  endtask

  task automatic sweepDataReads();
    testNo <= 2;
    for (int i = 0; i < ReadCount; i++) begin
      dataAccess(DataBase + addr_t'(4 * i), 1'b0, '0);
    end
    dataIdle();
  endtask

  task automatic writeThenRead();
    addr_t a;
    addr_t base;
    testNo <= 3;
    for (int k = 0; k < 4; k++) begin
      a    = DataBase + 32'h104 + addr_t'(k) * 32'h144;
      base = a & ~addr_t'(4 * `BLOCK_WORDS - 1);
      dataAccess(a, 1'b1, word_t'($random(seed)));
      dataAccess(a, 1'b0, '0);
      // rest of the block untouched
      for (int w = 0; w < `BLOCK_WORDS; w++) begin
        if (base + addr_t'(4 * w) != a) begin
          dataAccess(base + addr_t'(4 * w), 1'b0, '0);
        end
      end
    end
    dataIdle();
  endtask

  task automatic evictDirtyBlocks();
    addr_t base;
    testNo <= 4;
    // two ways, four dirty blocks, so victims go back to memory
    for (int k = 0; k < 4; k++) begin
      base = EvictBase + addr_t'(k) * 32'h80;
      dataAccess(base, 1'b1, word_t'($random(seed)));
      dataAccess(base + 32'h8, 1'b1, word_t'($random(seed)));
    end
    for (int k = 0; k < 4; k++) begin
      base = EvictBase + addr_t'(k) * 32'h80;
      for (int w = 0; w < `BLOCK_WORDS; w++) begin
        dataAccess(base + addr_t'(4 * w), 1'b0, '0);
      end
    end
    dataIdle();
  endtask

  task automatic mixTraffic();
    // stimulus drawn up front so the order is fixed
    for (int i = 0; i < MixCount; i++) begin
      mixAddr[i]  = DataBase | (addr_t'($random(seed)) & 32'h7fc);
      mixWrite[i] = 1'($random(seed) & 1);
      mixData[i]  = word_t'($random(seed));
      mixFetch[i] = InstrBase | (addr_t'($random(seed)) & 32'h3fc);
    end
    testNo <= 5;
    fork
      begin
        for (int i = 0; i < MixCount; i++) begin
          dataAccess(mixAddr[i], mixWrite[i], mixData[i]);
        end
        dataIdle();
      end
      begin
        for (int i = 0; i < MixCount; i++) begin
          fetchWord(mixFetch[i]);
        end
        fetchOn <= 1'b0;
      end
    join
  endtask

  initial begin
    seed       = 32'hb5c7_b2ba;
    cycles     = 0;
    pcF        = InstrBase;
    dataAdrM   = DataBase;
    writeDataM = '0;
    memWriteM  = 1'b0;
    memReadM   = 1'b0;
    fetchOn    = 1'b0;
    testNo     = 0;
    for (int n = 0; n < `MEM_WORDS; n++) begin
      shadow[n] = initWord(n);
    end
    // still in reset
    repeat (5) @(posedge clk);
    checkValue("reset iStall", '0, word_t'(iStall));
    checkValue("reset dStall", '0, word_t'(dStall));
    while (!arstN) begin
      @(posedge clk);
    end
    // first edge out of reset, nothing presented yet
    checkValue("idle iStall", '0, word_t'(iStall));
    checkValue("idle dStall", '0, word_t'(dStall));
    repeat (4) @(posedge clk);
    checkValue("idle dStall", '0, word_t'(dStall));
    sweepFetches();
    sweepDataReads();
    writeThenRead();
    evictDirtyBlocks();
    mixTraffic();
    repeat (2) @(posedge clk);
    finishRun();
  end

endmodule

//--- bench/memSystem_chk.sv
`include "memsys_config.svh"

module memSystemChk (
  input logic                clk,
  input logic                arstN,
  input memsys_pkg::busReq_t memReq,
  input memsys_pkg::busRsp_t memRsp,
  input logic                iStall,
  input logic                dStall
);

  timeunit 1ns;
  timeprecision 1ps;

  // read back by the testbench at the end of the run
  int assertFails = 0;

  // granted request held as is until its ready pulse
  reqStable: assert property (@(posedge clk) disable iff (!arstN)
    (memReq.request && !memRsp.ready) |=> $stable(memReq))
  else begin
    assertFails++;
    $error("memory request changed before its ready pulse");
  end

  // ready only answers a request that has been up for the whole latency
  readyWithReq: assert property (@(posedge clk) disable iff (!arstN)
    memRsp.ready |-> (memReq.request && $past(memReq.request, `MEM_LATENCY)))
  else begin
    assertFails++;
    $error("ready pulse without a request held for the memory latency");
  end

  // no stall while reset is held
  resetNoStall: assert property (@(posedge clk)
    !arstN |-> (!iStall && !dStall))
  else begin
    assertFails++;
    $error("stall raised during reset");
  end

endmodule

// memReq and memRsp are the arbiter's memory side
bind memSystem memSystemChk i_memSystemChk (
  .clk    (clk),
  .arstN  (arstN),
  .memReq (memReq),
  .memRsp (memRsp),
  .iStall (iStall),
  .dStall (dStall)
);

//--- bench/clockGen.sv
module clockGen (
  output logic clk,
  output logic arstN
);

  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for 10 rising edges, released on an edge
  initial begin
    arstN = 1'b0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

//--- hdl/memSystem.sv
module memSystem (
  input  logic              clk,
  input  logic              arstN,
  input  memsys_pkg::addr_t pcF,
  input  memsys_pkg::addr_t dataAdrM,
  input  memsys_pkg::word_t writeDataM,
  input  logic              memWriteM,
  input  logic              memReadM,
  output memsys_pkg::word_t instrF,
  output logic              iStall,
  output memsys_pkg::word_t readDataM,
  output logic              dStall
);

  import memsys_pkg::*;

  // cache side of the arbiter
  busReq_t iReq;
  busReq_t dReq;
  busRsp_t iRsp;
  busRsp_t dRsp;
  // memory side
  busReq_t memReq;
  busRsp_t memRsp;

  // fetch port
  instrCache i_instrCache (
    .clk    (clk),
    .arstN  (arstN),
    .pcF    (pcF),
    .busRsp (iRsp),
    .instrF (instrF),
    .iStall (iStall),
    .busReq (iReq)
  );

  // load/store port
  dataCache i_dataCache (
    .clk        (clk),
    .arstN      (arstN),
    .dataAdrM   (dataAdrM),
    .writeDataM (writeDataM),
    .memWriteM  (memWriteM),
    .memReadM   (memReadM),
    .busRsp     (dRsp),
    .readDataM  (readDataM),
    .dStall     (dStall),
    .busReq     (dReq)
  );

  busArbiter i_busArbiter (
    .clk    (clk),
    .arstN  (arstN),
    .iReq   (iReq),
    .dReq   (dReq),
    .memRsp (memRsp),
    .memReq (memReq),
    .iRsp   (iRsp),
    .dRsp   (dRsp)
  );

  blockMemory i_blockMemory (
    .clk    (clk),
    .arstN  (arstN),
    .memReq (memReq),
    .memRsp (memRsp)
  );

endmodule

//--- hdl/blockMemory.sv
`include "memsys_config.svh"

module blockMemory (
  input  logic                clk,
  input  logic                arstN,
  input  memsys_pkg::busReq_t memReq,
  output memsys_pkg::busRsp_t memRsp
);

  import memsys_pkg::*;

  localparam int CntW     = $clog2(`MEM_LATENCY + 1);
  localparam int BlkLsb   = 2 + $bits(wordSel_t);
  localparam int BlkIdxW  = $clog2(`MEM_WORDS) - $bits(wordSel_t);

  word_t               mem [`MEM_WORDS];
  logic [CntW-1:0]     cnt;
  logic [BlkIdxW-1:0]  blockIdx;

  // block number inside the array
  assign blockIdx = memReq.addr[BlkLsb +: BlkIdxW];

  // latency counter
  // cycle 0 is the first request cycle, ready on cycle MEM_LATENCY
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cnt <= '0;
    end else if (memRsp.ready || !memReq.request) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // read side, whole block at once
  always_comb begin
    memRsp.ready = memReq.request && (cnt == CntW'(`MEM_LATENCY));
    for (int w = 0; w < `BLOCK_WORDS; w++) begin
      memRsp.rdata[w] = mem[{blockIdx, wordSel_t'(w)}];
    end
  end

  // known contents after reset
  // word n holds n * 9e3779b1 + n
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int n = 0; n < `MEM_WORDS; n++) begin
        mem[n] <= word_t'(n) * 32'h9e37_79b1 + word_t'(n);
      end
    end else if (memRsp.ready && memReq.write) begin
      // block write commits on the ready edge
      for (int w = 0; w < `BLOCK_WORDS; w++) begin
        mem[{blockIdx, wordSel_t'(w)}] <= memReq.wdata[w];
      end
    end
  end

endmodule

//--- hdl/busArbiter.sv
module busArbiter (
  input  logic                clk,
  input  logic                arstN,
  input  memsys_pkg::busReq_t iReq,
  input  memsys_pkg::busReq_t dReq,
  input  memsys_pkg::busRsp_t memRsp,
  output memsys_pkg::busReq_t memReq,
  output memsys_pkg::busRsp_t iRsp,
  output memsys_pkg::busRsp_t dRsp
);

  import memsys_pkg::*;

  // who holds the bus
  typedef enum logic [1:0] {OWNER_NONE, OWNER_INSTR, OWNER_DATA} owner_t;

  owner_t owner;
  owner_t grant;

  // idle bus goes to a new requester right away, data first
  always_comb begin
    grant = owner;
    if (owner == OWNER_NONE) begin
      if (dReq.request) begin
        grant = OWNER_DATA;
      end else if (iReq.request) begin
        grant = OWNER_INSTR;
      end
    end
  end

  // grant sticks until the ready pulse
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      owner <= OWNER_NONE;
    end else if (memRsp.ready) begin
      owner <= OWNER_NONE;
    end else begin
      owner <= grant;
    end
  end

  always_comb begin
    case (grant)
      OWNER_DATA:  memReq = dReq;
      OWNER_INSTR: memReq = iReq;
      default:     memReq = '0;
    endcase
  end

  // read data fans out, ready only to the owner
  always_comb begin
    iRsp.rdata = memRsp.rdata;
    dRsp.rdata = memRsp.rdata;
    iRsp.ready = memRsp.ready && (grant == OWNER_INSTR);
    dRsp.ready = memRsp.ready && (grant == OWNER_DATA);
  end

endmodule

//--- hdl/dataCache.sv
`include "memsys_config.svh"

module dataCache (
  input  logic                clk,
  input  logic                arstN,
  input  memsys_pkg::addr_t   dataAdrM,
  input  memsys_pkg::word_t   writeDataM,
  input  logic                memWriteM,
  input  logic                memReadM,
  input  memsys_pkg::busRsp_t busRsp,
  output memsys_pkg::word_t   readDataM,
  output logic                dStall,
  output memsys_pkg::busReq_t busReq
);

  import memsys_pkg::*;

  // address field positions
  localparam int SelLsb = 2;
  localparam int SetLsb = SelLsb + $bits(wordSel_t);
  localparam int TagLsb = SetLsb + $bits(dIndex_t);

  // two ways per set
  dTag_t                         tagArr   [2][`DCACHE_SETS];
  block_t                        blockArr [2][`DCACHE_SETS];
  logic [1:0][`DCACHE_SETS-1:0] valid;
  logic [1:0][`DCACHE_SETS-1:0] dirty;
  // per set, the way to evict next
  logic [`DCACHE_SETS-1:0]      lru;

  dState_t  state;
  dState_t  stateNext;
  wordSel_t sel;
  dIndex_t  set;
  dTag_t    tag;
  logic     access;
  logic [1:0] hitVec;
  logic     hit;
  logic     hitWay;
  logic     miss;
  logic     hitAccess;
  logic     victim;
  logic     victimDirty;
  addr_t    victimAddr;
  addr_t    fillAddr;
  logic     refillDone;

  assign sel = dataAdrM[SelLsb +: $bits(wordSel_t)];
  assign set = dataAdrM[SetLsb +: $bits(dIndex_t)];
  assign tag = dataAdrM[TagLsb +: $bits(dTag_t)];

  assign access = memReadM || memWriteM;

  // tag compare in both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hitVec[w] = valid[w][set] && (tagArr[w][set] == tag);
    end
  end

  assign hit       = |hitVec;
  assign hitWay    = hitVec[1];
  assign miss      = access && !hit;
  assign hitAccess = (state == DCACHE_IDLE) && access && hit;

  // victim stays put while stalled, lru only moves on hits
  assign victim      = lru[set];
  assign victimDirty = valid[victim][set] && dirty[victim][set];
  // write back goes to the victim's own block address
  assign victimAddr  = {tagArr[victim][set], set, {SetLsb{1'b0}}};
  assign fillAddr    = {dataAdrM[31:SetLsb], {SetLsb{1'b0}}};

  assign refillDone = (state == DCACHE_REFILL) && busRsp.ready;

  assign readDataM = blockArr[hitWay][set][sel];
  assign dStall    = (state != DCACHE_IDLE) || miss;

  // miss cycle already drives the first transfer
  always_comb begin
    busReq         = '0;
    busReq.addr    = fillAddr;
    busReq.wdata   = blockArr[victim][set];
    case (state)
      DCACHE_IDLE: begin
        busReq.request = miss;
        busReq.write   = victimDirty;
        if (victimDirty) begin
          busReq.addr = victimAddr;
        end
      end
      DCACHE_WRITEBACK: begin
        busReq.request = 1'b1;
        busReq.write   = 1'b1;
        busReq.addr    = victimAddr;
      end
      DCACHE_REFILL: begin
        busReq.request = 1'b1;
      end
      default: busReq.request = 1'b0;
    endcase
  end

  always_comb begin
    stateNext = state;
    case (state)
      DCACHE_IDLE: begin
        if (miss) begin
          stateNext = victimDirty ? DCACHE_WRITEBACK : DCACHE_REFILL;
        end
      end
      DCACHE_WRITEBACK: begin
        // victim committed, now fetch the new block
        if (busRsp.ready) begin
          stateNext = DCACHE_REFILL;
        end
      end
      DCACHE_REFILL: begin
        if (busRsp.ready) begin
          stateNext = DCACHE_IDLE;
        end
      end
      default: stateNext = DCACHE_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= DCACHE_IDLE;
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      state <= stateNext;
      if (hitAccess) begin
        // the other way becomes the next victim
        lru[set] <= ~hitWay;
        if (memWriteM) begin
          dirty[hitWay][set] <= 1'b1;
        end
      end
      if (refillDone) begin
        // allocated clean, pending write lands next cycle as a hit
        valid[victim][set] <= 1'b1;
        dirty[victim][set] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hitAccess && memWriteM) begin
      blockArr[hitWay][set][sel] <= writeDataM;
    end
    if (refillDone) begin
      tagArr[victim][set]   <= tag;
      blockArr[victim][set] <= busRsp.rdata;
    end
  end

endmodule

//--- hdl/instrCache.sv
`include "memsys_config.svh"

module instrCache (
  input  logic                clk,
  input  logic                arstN,
  input  memsys_pkg::addr_t   pcF,
  input  memsys_pkg::busRsp_t busRsp,
  output memsys_pkg::word_t   instrF,
  output logic                iStall,
  output memsys_pkg::busReq_t busReq
);

  import memsys_pkg::*;

  // address field positions
  localparam int SelLsb = 2;
  localparam int IdxLsb = SelLsb + $bits(wordSel_t);
  localparam int TagLsb = IdxLsb + $bits(iIndex_t);

  // line storage
  iTag_t                    tagArr   [`ICACHE_LINES];
  block_t                   blockArr [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid;

  iState_t  state;
  iState_t  stateNext;
  logic     fetchEn;
  wordSel_t sel;
  iIndex_t  idx;
  iTag_t    tag;
  logic     hit;
  logic     fetchMiss;
  logic     refillDone;

  // split the fetch address
  assign sel = pcF[SelLsb +: $bits(wordSel_t)];
  assign idx = pcF[IdxLsb +: $bits(iIndex_t)];
  assign tag = pcF[TagLsb +: $bits(iTag_t)];

  // lookup
  assign hit       = valid[idx] && (tagArr[idx] == tag);
  // fetching starts on the first edge out of reset
  assign fetchMiss = fetchEn && !hit;

  assign refillDone = (state == ICACHE_REFILL) && busRsp.ready;

  // hit data straight from the array
  assign instrF = blockArr[idx][sel];
  assign iStall = (state == ICACHE_REFILL) || fetchMiss;

  // read request goes out in the miss cycle itself
  always_comb begin
    busReq         = '0;
    busReq.request = (state == ICACHE_REFILL) || fetchMiss;
    busReq.addr    = {pcF[31:IdxLsb], {IdxLsb{1'b0}}};
  end

  always_comb begin
    stateNext = state;
    case (state)
      ICACHE_IDLE: begin
        if (fetchMiss) begin
          stateNext = ICACHE_REFILL;
        end
      end
      ICACHE_REFILL: begin
        // line written on this edge, hit next cycle
        if (busRsp.ready) begin
          stateNext = ICACHE_IDLE;
        end
      end
      default: stateNext = ICACHE_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= ICACHE_IDLE;
      valid   <= '0;
      fetchEn <= 1'b0;
    end else begin
      state   <= stateNext;
      fetchEn <= 1'b1;
      if (refillDone) begin
        valid[idx] <= 1'b1;
      end
    end
  end

  // tag and block fill
  always_ff @(posedge clk) begin
    if (refillDone) begin
      tagArr[idx]   <= tag;
      blockArr[idx] <= busRsp.rdata;
    end
  end

endmodule

//--- hdl/memsys_pkg.sv
`include "memsys_config.svh"

package memsys_pkg;

  // one data or instruction word
  typedef logic [31:0] word_t;
  // byte address
  typedef logic [31:0] addr_t;

  // whole cache block, word 0 sits in the low bits
  typedef word_t [`BLOCK_WORDS-1:0] block_t;

  // word select inside a block
  typedef logic [$clog2(`BLOCK_WORDS)-1:0] wordSel_t;

  // line index of the instruction cache, set index of the data cache
  typedef logic [$clog2(`ICACHE_LINES)-1:0] iIndex_t;
  typedef logic [$clog2(`DCACHE_SETS)-1:0]  dIndex_t;

  // tags hold everything above the index bits
  typedef logic [29-$clog2(`BLOCK_WORDS)-$clog2(`ICACHE_LINES):0] iTag_t;
  typedef logic [29-$clog2(`BLOCK_WORDS)-$clog2(`DCACHE_SETS):0]  dTag_t;

  // cache to memory, request is a level held until ready
  typedef struct packed {
    logic   request;
    logic   write;
    addr_t  addr;
    block_t wdata;
  } busReq_t;

  // memory to cache, ready is a single cycle pulse
  typedef struct packed {
    logic   ready;
    block_t rdata;
  } busRsp_t;

  typedef enum logic {ICACHE_IDLE, ICACHE_REFILL} iState_t;

  typedef enum logic [1:0] {DCACHE_IDLE, DCACHE_WRITEBACK, DCACHE_REFILL} dState_t;

endpackage

//--- include/memsys_config.svh
`ifndef MEMSYS_CONFIG_SVH
`define MEMSYS_CONFIG_SVH

// cache block geometry
// words per block, shared by both caches and the bus
`define BLOCK_WORDS 4

// instruction cache
// direct mapped, one block per line
`define ICACHE_LINES 16

// data cache
// sets of two ways each
`define DCACHE_SETS 8

// backing store size in 32-bit words
`define MEM_WORDS 1024

// block memory timing
// cycles from first request cycle to ready pulse
// must be at least 1
`define MEM_LATENCY 2

`endif
